// File: all.f
hw/weight_pkg.sv
hw/weight_fifo_if.sv
hw/weight_sync_fifo.sv
hw/weight_fetch.sv
hw/weight_dot_engine.sv
hw/weight_stream_top.sv
test/tb_clock.sv
test/weight_stream_properties.sv
test/weight_stream_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the weight stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    -f all.f \
    --top-module weight_stream_tb \
    -o sim_weight_stream
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sim_weight_stream > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi

if ! grep -q "ALL TESTS PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0

// File: test/weight_stream_tb.sv
`timescale 1ns/100ps

module weight_stream_tb
    import weight_pkg::*;
();

    typedef struct packed {
        logic                  is_restart;
        weight_prec_t          prec;
        logic [9:0]            words;
        logic [data_width-1:0] act;
        logic [15:0]           gap;      // idle cycles before the entry
    } test_entry_t;

    localparam int num_tests = 10;

    logic                        s_clk;
    logic                        s_rst;
    logic                        load_w_finish;
    logic [addr_size-1:0]        rd_burst_addr;
    logic [len_width-1:0]        rd_burst_len;
    logic                        rd_burst_req;
    logic [data_width-1:0]       rd_burst_data;
    logic                        rd_burst_valid;
    logic                        rd_burst_finish;
    logic                        cmd_valid;
    weight_prec_t                cmd_prec;
    logic [9:0]                  cmd_words;
    weight_word_u                cmd_act;
    logic                        res_valid;
    logic signed [acc_width-1:0] res_value;
    logic                        busy;
    logic                        weight_ready;

    test_entry_t          tests [num_tests];
    logic [31:0]          rng_state;
    logic [addr_size-1:0] exp_burst_addr;
    logic [addr_size-1:0] next_w_addr;   // byte address of the next weight the engine sees
    logic                 restart_pending;
    int                   skipped_bursts;
    int                   bursts_started;
    int                   error_count;
    int                   tests_passed;
    int                   tests_failed;

    tb_clock clk_gen (.s_clk(s_clk));

    weight_stream_top UUT (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // beat content depends only on its byte address
    function automatic logic [data_width-1:0] beat_data(input logic [addr_size-1:0] a);
        logic [31:0] lo;
        lo = xorshift(a);
        return {xorshift(lo), lo};
    endfunction

    function automatic logic signed [acc_width-1:0] model_dot(
        input logic [data_width-1:0] w,
        input logic [data_width-1:0] a,
        input weight_prec_t          p
    );
        logic signed [acc_width-1:0] s;
        logic signed [15:0]          w16;
        logic signed [15:0]          a16;
        logic signed [7:0]           w8;
        logic signed [7:0]           a8;
        s = '0;
        if (p == prec_int8) begin
            for (int i = 0; i < 8; i++) begin
                w8 = w[8*i +: 8];
                a8 = a[8*i +: 8];
                s  = s + w8 * a8;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                w16 = w[16*i +: 16];
                a16 = a[16*i +: 16];
                s   = s + w16 * a16;
            end
        end
        return s;
    endfunction

    task automatic check_result(input logic signed [acc_width-1:0] got,
                                input logic signed [acc_width-1:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s sum got %0d expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_addr(input logic [addr_size-1:0] got,
                              input logic [addr_size-1:0] exp, input string what);
        if (got !== exp) begin
            $display("ERR %0t: %s address got %h expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic check_len(input logic [len_width-1:0] got, input logic [len_width-1:0] exp);
        if (got !== exp) begin
            $display("ERR %0t: burst length got %0d expected %0d", $time, got, exp);
            error_count++;
        end
    endtask

    // DDR burst model
    initial begin
        logic [addr_size-1:0] a;
        logic [1:0]           gap;
        @(negedge s_clk);
        while (s_rst)
            @(negedge s_clk);
        forever begin
            @(negedge s_clk);
            if (rd_burst_req) begin
                a = rd_burst_addr;
                bursts_started++;
                check_len(rd_burst_len, len_width'(burst_beats));
                if (restart_pending && skipped_bursts == 0
                        && a != weights_qkv_baseaddr) begin
                    skipped_bursts++;   // opened before the reload was seen
                    check_addr(a, exp_burst_addr, "burst");
                end else if (restart_pending) begin
                    check_addr(a, weights_qkv_baseaddr, "burst after reload");
                    restart_pending = 1'b0;
                end else begin
                    check_addr(a, exp_burst_addr, "burst");
                end
                exp_burst_addr = a + addr_size'(burst_bytes);
                repeat (2) @(posedge s_clk);
                for (int b = 0; b < burst_beats; b++) begin
                    rng_state = xorshift(rng_state);
                    gap = rng_state[1:0];
                    repeat (gap) begin
                        @(posedge s_clk);
                        rd_burst_valid  <= 1'b0;
                        rd_burst_finish <= 1'b0;
                    end
                    @(posedge s_clk);
                    rd_burst_valid  <= 1'b1;
                    rd_burst_data   <= beat_data(a + addr_size'(8 * b));
                    rd_burst_finish <= (b == burst_beats - 1);  // with the last beat
                end
                @(posedge s_clk);
                rd_burst_valid  <= 1'b0;
                rd_burst_finish <= 1'b0;
                @(negedge s_clk);
                while (rd_burst_req)
                    @(negedge s_clk);
            end
        end
    end

    task automatic run_command(input int idx, input test_entry_t t);
        logic signed [acc_width-1:0] exp;
        int                          limit;
        int                          waited;
        int                          errs_before;
        errs_before = error_count;
        exp = '0;
        for (int k = 0; k < int'(t.words); k++)
            exp = exp + model_dot(beat_data(next_w_addr + addr_size'(8 * k)), t.act, t.prec);
        next_w_addr = next_w_addr + addr_size'(8 * int'(t.words));
        @(negedge s_clk);
        while (busy)
            @(negedge s_clk);
        @(posedge s_clk);
        cmd_valid <= 1'b1;
        cmd_prec  <= t.prec;
        cmd_words <= t.words;
        cmd_act   <= t.act;
        @(posedge s_clk);
        cmd_valid <= 1'b0;
        limit  = 40 * int'(t.words) + 200;
        waited = 0;
        @(negedge s_clk);
        while (!res_valid && waited < limit) begin
            @(negedge s_clk);
            waited++;
        end
        if (!res_valid) begin
            $display("test %0d: missing result after %0d cycles", idx, limit);
            error_count++;
        end else begin
            check_result(res_value, exp, $sformatf("test %0d", idx));
        end
        if (error_count == errs_before) begin
            tests_passed++;
            $display("test %0d: %s x %0d words, sum %0d ok", idx,
                     t.prec == prec_int8 ? "int8" : "int16", t.words, exp);
        end else begin
            tests_failed++;
            $display("test %0d: failed", idx);
        end
    endtask

    task automatic run_restart(input int idx);
        int errs_before;
        errs_before = error_count;
        @(posedge s_clk);
        load_w_finish   <= 1'b1;
        restart_pending = 1'b1;
        skipped_bursts  = 0;
        next_w_addr     = weights_qkv_baseaddr;
        @(posedge s_clk);
        load_w_finish <= 1'b0;
        repeat (3) @(posedge s_clk);   // let the flush settle before the next command
        @(negedge s_clk);
        if (weight_ready !== 1'b0) begin
            $display("test %0d: buffer still holds weights after reload", idx);
            error_count++;
        end
        if (error_count == errs_before) begin
            tests_passed++;
            $display("test %0d: weight reload flushed the buffer", idx);
        end else begin
            tests_failed++;
            $display("test %0d: failed", idx);
        end
    endtask

    task automatic idle_gap(input int cycles);
        int mid_count;
        repeat (cycles / 2) @(posedge s_clk);
        mid_count = bursts_started;
        repeat (cycles - cycles / 2) @(posedge s_clk);
        @(negedge s_clk);
        if (rd_burst_req || bursts_started != mid_count || !weight_ready) begin
            $display("requests did not stop while the buffer was near full");
            error_count++;
        end else begin
            $display("idle gap of %0d cycles: requests stopped near full", cycles);
        end
    endtask

    // watchdog
    initial begin
        int wd_cycles;
        @(negedge s_rst);   // start counting once reset is released
        wd_cycles = 2000;
        for (int i = 0; i < num_tests; i++)
            wd_cycles = wd_cycles + 40 * int'(tests[i].words) + int'(tests[i].gap);
        #(wd_cycles * 40);
        $display("watchdog: run did not end within %0d cycles", wd_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        tests[0] = '{1'b0, prec_int16, 10'd4,   64'h0003_fffe_7fff_8001, 16'd0};
        tests[1] = '{1'b0, prec_int16, 10'd20,  64'h1234_edcb_0101_ff00, 16'd0};
        tests[2] = '{1'b0, prec_int8,  10'd40,  64'h7f80_0102_fe03_40c1, 16'd0};
        tests[3] = '{1'b0, prec_int8,  10'd75,  64'h0102_0304_0506_0708, 16'd0};
        tests[4] = '{1'b0, prec_int16, 10'd1,   64'h0000_0001_0000_ffff, 16'd4000};
        tests[5] = '{1'b0, prec_int8,  10'd300, 64'h8181_7f7f_0000_2233, 16'd0};
        tests[6] = '{1'b1, prec_int16, 10'd0,   64'h0,                   16'd0};
        tests[7] = '{1'b0, prec_int16, 10'd10,  64'ha5a5_5a5a_0f0f_f0f0, 16'd0};
        tests[8] = '{1'b0, prec_int8,  10'd512, 64'hff01_ff01_80c0_e0f0, 16'd0};
        tests[9] = '{1'b0, prec_int16, 10'd33,  64'h7fff_7fff_8000_8000, 16'd0};
    end

    initial begin
        s_rst           = 1'b1;
        load_w_finish   = 1'b0;
        rd_burst_data   = '0;
        rd_burst_valid  = 1'b0;
        rd_burst_finish = 1'b0;
        cmd_valid       = 1'b0;
        cmd_prec        = prec_int16;
        cmd_words       = '0;
        cmd_act         = '0;
        rng_state       = 32'h723f_ba47;
        exp_burst_addr  = weights_qkv_baseaddr;
        next_w_addr     = weights_qkv_baseaddr;
        restart_pending = 1'b0;
        skipped_bursts  = 0;
        bursts_started  = 0;
        error_count     = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        repeat (4) @(posedge s_clk);
        s_rst <= 1'b0;
        @(negedge s_clk);
        if (rd_burst_req !== 1'b0 || res_valid !== 1'b0 || busy !== 1'b0) begin
            $display("outputs not idle after reset");
            error_count++;
        end
        for (int i = 0; i < num_tests; i++) begin
            if (tests[i].gap != 16'd0)
                idle_gap(int'(tests[i].gap));
            if (tests[i].is_restart)
                run_restart(i);
            else
                run_command(i, tests[i]);
        end
        repeat (5) @(posedge s_clk);
        $display("summary: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: test/weight_stream_properties.sv
`timescale 1ns/100ps

module weight_stream_properties
    import weight_pkg::*;
(
    input logic                 s_clk,
    input logic                 s_rst,
    input logic                 wr_en,
    input logic                 full,
    input logic                 rd_en,
    input logic                 empty,
    input logic                 req,
    input logic                 finish,
    input logic [addr_size-1:0] addr
);

    // beats into a full buffer would be lost
    a_no_write_full : assert property (@(posedge s_clk) disable iff (s_rst)
        wr_en |-> !full)
        else $error("write while buffer full");

    // a pop must never find the occupancy at zero
    a_no_read_empty : assert property (@(posedge s_clk) disable iff (s_rst)
        rd_en |-> !empty)
        else $error("read while buffer empty");

    // request only drops after the burst is closed
    a_req_falls_on_finish : assert property (@(posedge s_clk) disable iff (s_rst)
        $fell(req) |-> $past(finish))
        else $error("burst request fell without finish");

    a_addr_stable : assert property (@(posedge s_clk) disable iff (s_rst)
        (req && $past(req)) |-> $stable(addr))
        else $error("burst address moved during open request");

endmodule

bind weight_sync_fifo weight_stream_properties fifo_props (
    .s_clk (s_clk), .s_rst (s_rst), .wr_en (ff.wr_en), .full (full),
    .rd_en (ff.rd_en), .empty (count == '0), .req (1'b0), .finish (1'b0),
    .addr ({weight_pkg::addr_size{1'b0}})
);

bind weight_fetch weight_stream_properties fetch_props (
    .s_clk (s_clk), .s_rst (s_rst), .wr_en (1'b0), .full (1'b0),
    .rd_en (1'b0), .empty (1'b0), .req (rd_burst_req), .finish (rd_burst_finish),
    .addr (rd_burst_addr)
);

// File: test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic s_clk
);

    localparam realtime half_period = 20.0;   // 40 ns period

    initial begin
        s_clk = 1'b0;
        forever #(half_period) s_clk = ~s_clk;
    end

endmodule

// File: hw/weight_stream_top.sv
`timescale 1ns/100ps

module weight_stream_top
    import weight_pkg::*;
(
    input  logic                        s_clk,
    input  logic                        s_rst,
    input  logic                        load_w_finish,
    // DDR burst port
    output logic [addr_size-1:0]        rd_burst_addr,
    output logic [len_width-1:0]        rd_burst_len,
    output logic                        rd_burst_req,
    input  logic [data_width-1:0]       rd_burst_data,
    input  logic                        rd_burst_valid,
    input  logic                        rd_burst_finish,
    // command and result
    input  logic                        cmd_valid,
    input  weight_prec_t                cmd_prec,
    input  logic [9:0]                  cmd_words,
    input  weight_word_u                cmd_act,
    output logic                        res_valid,
    output logic signed [acc_width-1:0] res_value,
    output logic                        busy,
    output logic                        weight_ready   // level only, no handshake
);

    weight_fifo_if fifo_bus ();

    assign weight_ready = ~fifo_bus.prog_empty;

    weight_fetch u_fetch (
        .s_clk           (s_clk),
        .s_rst           (s_rst),
        .load_w_finish   (load_w_finish),
        .rd_burst_data   (rd_burst_data),
        .rd_burst_valid  (rd_burst_valid),
        .rd_burst_finish (rd_burst_finish),
        .rd_burst_addr   (rd_burst_addr),
        .rd_burst_len    (rd_burst_len),
        .rd_burst_req    (rd_burst_req),
        .ff              (fifo_bus)
    );

    weight_sync_fifo u_fifo (
        .s_clk (s_clk),
        .s_rst (s_rst),
        .ff    (fifo_bus)
    );

    weight_dot_engine u_engine (
        .s_clk     (s_clk),
        .s_rst     (s_rst),
        .cmd_valid (cmd_valid),
        .cmd_prec  (cmd_prec),
        .cmd_words (cmd_words),
        .cmd_act   (cmd_act),
        .res_valid (res_valid),
        .res_value (res_value),
        .busy      (busy),
        .ff        (fifo_bus)
    );

endmodule

// File: hw/weight_dot_engine.sv
`timescale 1ns/100ps

module weight_dot_engine
    import weight_pkg::*;
(
    input  logic                        s_clk,
    input  logic                        s_rst,
    input  logic                        cmd_valid,
    input  weight_prec_t                cmd_prec,
    input  logic [9:0]                  cmd_words,
    input  weight_word_u                cmd_act,
    output logic                        res_valid,
    output logic signed [acc_width-1:0] res_value,
    output logic                        busy,
    weight_fifo_if.consumer             ff
);

    logic [9:0]                  words_left;
    weight_prec_t                prec_q;
    weight_word_u                act_q;
    weight_word_u                w_word;
    logic                        cmd_accept;
    logic                        pop;
    logic                        pop_last;
    logic                        dec_valid;
    logic                        dec_last;
    logic signed [acc_width-1:0] lane_prod [lanes8];
    logic signed [acc_width-1:0] exe_prod  [lanes8];
    logic                        exe_valid;
    logic                        exe_last;
    logic signed [acc_width-1:0] lane_sum;
    logic signed [acc_width-1:0] acc;

    assign cmd_accept = cmd_valid && !busy;
    assign pop        = busy && (words_left != '0) && !ff.empty;  // stall on empty
    assign pop_last   = pop && (words_left == 10'd1);
    assign ff.rd_en   = pop;
    assign w_word     = ff.rd_data;

    // command latch and word counter
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            busy       <= 1'b0;
            words_left <= '0;
            prec_q     <= prec_int16;
            act_q      <= '0;
        end else if (cmd_accept) begin
            busy       <= 1'b1;
            words_left <= cmd_words;
            prec_q     <= cmd_prec;
            act_q      <= cmd_act;
        end else begin
            if (pop)
                words_left <= words_left - 10'd1;
            if (exe_valid && exe_last)
                busy <= 1'b0;   // drops together with res_valid
        end
    end

    // decode stage, word sits in the FIFO read register
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            dec_valid <= 1'b0;
            dec_last  <= 1'b0;
        end else begin
            dec_valid <= pop;
            dec_last  <= pop_last;
        end
    end

    // lane products in the latched precision
    always_comb begin
        if (prec_q == prec_int8) begin
            for (int i = 0; i < lanes8; i++)
                lane_prod[i] = $signed(w_word.w8[i]) * $signed(act_q.w8[i]);
        end else begin
            for (int i = 0; i < lanes16; i++)
                lane_prod[i] = $signed(w_word.w16[i]) * $signed(act_q.w16[i]);
            for (int i = lanes16; i < lanes8; i++)
                lane_prod[i] = '0;   // upper lanes unused in int16
        end
    end

    // execute stage
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            exe_valid <= 1'b0;
            exe_last  <= 1'b0;
            for (int i = 0; i < lanes8; i++)
                exe_prod[i] <= '0;
        end else begin
            exe_valid <= dec_valid;
            exe_last  <= dec_last;
            if (dec_valid)
                exe_prod <= lane_prod;
        end
    end

    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < lanes8; i++)
            lane_sum = lane_sum + exe_prod[i];   // 32-bit wraparound
    end

    // result stage
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            acc       <= '0;
            res_valid <= 1'b0;
            res_value <= '0;
        end else begin
            res_valid <= exe_valid && exe_last;
            if (cmd_accept)
                acc <= '0;
            else if (exe_valid)
                acc <= acc + lane_sum;
            if (exe_valid && exe_last)
                res_value <= acc + lane_sum;
        end
    end

endmodule

// File: hw/weight_fetch.sv
`timescale 1ns/100ps

module weight_fetch
    import weight_pkg::*;
(
    input  logic                   s_clk,
    input  logic                   s_rst,
    input  logic                   load_w_finish,
    input  logic [data_width-1:0]  rd_burst_data,
    input  logic                   rd_burst_valid,
    input  logic                   rd_burst_finish,
    output logic [addr_size-1:0]   rd_burst_addr,
    output logic [len_width-1:0]   rd_burst_len,
    output logic                   rd_burst_req,
    weight_fifo_if.producer        ff
);

    logic restart_flag;   // reload requested, waiting for the open burst to close

    assign rd_burst_len = len_width'(burst_beats);

    // beats go straight into the buffer
    assign ff.wr_en   = rd_burst_valid;
    assign ff.wr_data = rd_burst_data;
    assign ff.flush   = restart_flag;

    // burst address
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            rd_burst_addr <= weights_qkv_baseaddr;
        end else if (restart_flag && !rd_burst_req) begin
            // back to base once no burst is open, so the address
            // never moves under an active request
            rd_burst_addr <= weights_qkv_baseaddr;
        end else if (rd_burst_finish) begin
            rd_burst_addr <= rd_burst_addr + addr_size'(burst_bytes);
        end
    end

    // request level, one burst at a time
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst)
            rd_burst_req <= 1'b0;
        else if (rd_burst_finish)
            rd_burst_req <= 1'b0;
        else if (!rd_burst_req && !ff.prog_full)
            rd_burst_req <= 1'b1;
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst)
            restart_flag <= 1'b0;
        else if (load_w_finish)
            restart_flag <= 1'b1;
        else if (!rd_burst_req)
            restart_flag <= 1'b0;   // clears in the first idle cycle
    end

endmodule

// File: hw/weight_sync_fifo.sv
`timescale 1ns/100ps

module weight_sync_fifo
    import weight_pkg::*;
(
    input  logic          s_clk,
    input  logic          s_rst,
    weight_fifo_if.buffer ff
);

    logic [data_width-1:0]     mem [fifo_depth];
    logic [fifo_ptr_width-1:0] wr_ptr;
    logic [fifo_ptr_width-1:0] rd_ptr;
    logic [fifo_cnt_width-1:0] count;
    logic [fifo_cnt_width-1:0] count_next;
    logic                      full;
    logic                      wr_ok;
    logic                      rd_ok;

    assign full  = (count == fifo_cnt_width'(fifo_depth));
    assign wr_ok = ff.wr_en && !full;      // beats into a full buffer are lost
    assign rd_ok = ff.rd_en && !ff.empty;

    always_comb begin
        if (ff.flush)
            count_next = '0;
        else
            count_next = count + fifo_cnt_width'(wr_ok) - fifo_cnt_width'(rd_ok);
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            count <= count_next;
            if (ff.flush) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (wr_ok)
                    wr_ptr <= wr_ptr + 1'b1;   // wraps at fifo_depth
                if (rd_ok)
                    rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // flags follow the occupancy after this edge
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            ff.empty      <= 1'b1;
            ff.prog_full  <= 1'b0;
            ff.prog_empty <= 1'b1;
        end else begin
            ff.empty      <= (count_next == '0);
            ff.prog_full  <= (count_next >= fifo_cnt_width'(prog_full_level));
            ff.prog_empty <= (count_next <  fifo_cnt_width'(prog_empty_level));
        end
    end

    always_ff @(posedge s_clk) begin
        if (wr_ok)
            mem[wr_ptr] <= ff.wr_data;
    end

    always_ff @(posedge s_clk) begin
        if (rd_ok)
            ff.rd_data <= mem[rd_ptr];  // registered read port
    end

endmodule

// File: hw/weight_fifo_if.sv
`timescale 1ns/100ps

interface weight_fifo_if
    import weight_pkg::*;
();

    logic                  wr_en;
    logic [data_width-1:0] wr_data;
    logic                  flush;      // held while a weight reload is pending
    logic                  rd_en;
    logic [data_width-1:0] rd_data;    // valid the cycle after rd_en
    logic                  empty;
    logic                  prog_full;
    logic                  prog_empty;

    modport producer (
        output wr_en, wr_data, flush,
        input  prog_full
    );

    modport buffer (
        input  wr_en, wr_data, flush, rd_en,
        output rd_data, empty, prog_full, prog_empty
    );

    modport consumer (
        output rd_en,
        input  rd_data, empty
    );

endinterface

// File: hw/weight_pkg.sv
package weight_pkg;

    // DDR side
    localparam int data_width = 64;     // one beat, one weight word
    localparam int addr_size  = 32;
    localparam int len_width  = 8;

    localparam int burst_beats = 32;
    localparam int burst_bytes = burst_beats * (data_width / 8);   // 256

    localparam logic [addr_size-1:0] weights_qkv_baseaddr = 32'h0010_0000;

    // weight buffer
    localparam int fifo_depth       = 512;
    localparam int fifo_ptr_width   = $clog2(fifo_depth);
    localparam int fifo_cnt_width   = fifo_ptr_width + 1;  // holds 0 .. fifo_depth
    localparam int prog_full_level  = 448;  // 64 entries of headroom for an open burst
    localparam int prog_empty_level = 64;

    // dot product
    localparam int acc_width = 32;
    localparam int lanes16   = data_width / 16;
    localparam int lanes8    = data_width / 8;

    typedef enum logic {
        prec_int16 = 1'b0,
        prec_int8  = 1'b1
    } weight_prec_t;

    // named signed lane types keep each selected lane signed
    typedef logic signed [15:0] lane16_t;
    typedef logic signed [7:0]  lane8_t;

    // one word, two views
    typedef union packed {
        lane16_t [lanes16-1:0] w16;
        lane8_t  [lanes8-1:0]  w8;
    } weight_word_u;

endpackage
